/* hw/conv_param_defs.svh */
`ifndef CONV_PARAM_DEFS_SVH
`define CONV_PARAM_DEFS_SVH

// Parameter buffer geometry.
`define CP_DEPTH 8
`define CP_AW    3
`define CP_DW    32

// SRAM write request levels.
`define CP_WRITE_ENB 1'b1
`define CP_WRITE_DIS 1'b0

`endif

/* hw/conv_param_pkg.sv */
`include "conv_param_defs.svh"

package conv_param_pkg;

  // One buffer word, read either as a weight or as the layer setup.
  typedef union packed {
    logic signed [`CP_DW-1:0] raw;
    struct packed {
      logic [7:0] out_ch;
      logic [7:0] in_ch;
      logic [3:0] kernel;
      logic [3:0] stride;
      logic [3:0] pad;
      logic [3:0] reserved;
    } cfg;
  } param_word_u;

  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,
    ARB_ENGINE  = 2'd1,
    ARB_HOST_RD = 2'd2,
    ARB_HOST_WR = 2'd3
  } arb_state_e;

endpackage

/* hw/param_sram.sv */
`timescale 1ns/1ps
`include "conv_param_defs.svh"

module param_sram (
  input  logic              clk,
  input  logic              cs_i,
  input  logic              we_i,
  input  logic [`CP_AW-1:0] addr_i,
  input  logic [`CP_DW-1:0] wdata_i,
  output logic [`CP_DW-1:0] rdata_o
);

  logic [`CP_DW-1:0] mem [`CP_DEPTH];

  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (we_i == `CP_WRITE_ENB) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];  // Data shows up one cycle after the select.
      end
    end
  end

endmodule

/* hw/param_buffer_arbiter.sv */
`timescale 1ns/1ps
`include "conv_param_defs.svh"

module param_buffer_arbiter
  import conv_param_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              eng_busy_i,
  input  logic              eng_cs_i,
  input  logic [`CP_AW-1:0] eng_addr_i,
  input  logic              rd_pending_i,
  input  logic              wr_pending_i,
  input  logic [`CP_AW-1:0] host_addr_i,
  input  logic [`CP_DW-1:0] host_wdata_i,
  input  logic              host_last_i,
  input  logic [`CP_DW-1:0] sram_rdata_i,
  output logic              eng_grant_o,
  output logic [`CP_DW-1:0] eng_rdata_o,
  output logic              host_grant_rd_o,
  output logic              host_grant_wr_o,
  output logic [`CP_DW-1:0] host_rdata_o,
  output logic              host_rvalid_o,
  output logic              sram_cs_o,
  output logic              sram_we_o,
  output logic [`CP_AW-1:0] sram_addr_o,
  output logic [`CP_DW-1:0] sram_wdata_o
);

  arb_state_e state_q, next_state;
  logic       rd_cs_q;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= ARB_IDLE;
      rd_cs_q <= 1'b0;
    end else begin
      state_q <= next_state;
      rd_cs_q <= (state_q == ARB_HOST_RD);  // Every host read beat selects the SRAM.
    end
  end

  always_comb begin
    next_state = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (eng_busy_i) begin
          next_state = ARB_ENGINE;
        end else if (rd_pending_i) begin
          next_state = ARB_HOST_RD;
        end else if (wr_pending_i) begin
          next_state = ARB_HOST_WR;
        end
      end
      ARB_ENGINE:  if (!eng_busy_i) next_state = ARB_IDLE;
      ARB_HOST_RD: if (host_last_i) next_state = ARB_IDLE;
      ARB_HOST_WR: if (host_last_i) next_state = ARB_IDLE;
      default:     next_state = ARB_IDLE;
    endcase
  end

  // SRAM port steering.
  always_comb begin
    sram_cs_o    = 1'b0;
    sram_we_o    = `CP_WRITE_DIS;
    sram_addr_o  = '0;
    sram_wdata_o = '0;
    case (state_q)
      ARB_ENGINE: begin
        sram_cs_o   = eng_cs_i;
        sram_addr_o = eng_addr_i;
      end
      ARB_HOST_RD: begin
        sram_cs_o   = 1'b1;
        sram_addr_o = host_addr_i;
      end
      ARB_HOST_WR: begin
        sram_cs_o    = 1'b1;
        sram_we_o    = `CP_WRITE_ENB;
        sram_addr_o  = host_addr_i;
        sram_wdata_o = host_wdata_i;
      end
      default: ;
    endcase
  end

  assign eng_grant_o     = (state_q == ARB_ENGINE);
  assign host_grant_rd_o = (state_q == ARB_HOST_RD);
  assign host_grant_wr_o = (state_q == ARB_HOST_WR);
  assign eng_rdata_o     = sram_rdata_i;
  assign host_rdata_o    = sram_rdata_i;
  assign host_rvalid_o   = rd_cs_q;

endmodule

/* hw/host_bus_port.sv */
`timescale 1ns/1ps
`include "conv_param_defs.svh"

module host_bus_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_req_i,
  input  logic [`CP_AW-1:0] rd_addr_i,
  input  logic [`CP_AW:0]   rd_len_i,
  input  logic              wr_req_i,
  input  logic [`CP_AW-1:0] wr_addr_i,
  input  logic [`CP_DW-1:0] wr_data_i,
  input  logic              grant_rd_i,
  input  logic              grant_wr_i,
  input  logic [`CP_DW-1:0] rdata_i,
  input  logic              rvalid_i,
  output logic              rd_pending_o,
  output logic              wr_pending_o,
  output logic [`CP_AW-1:0] addr_o,
  output logic [`CP_DW-1:0] wdata_o,
  output logic              last_o,
  output logic [`CP_DW-1:0] rdata_o,
  output logic              rvalid_o,
  output logic              rlast_o,
  output logic              wr_done_o
);

  logic [`CP_AW-1:0] len_m1_q;
  logic [`CP_AW-1:0] issue_cnt_q;
  logic [`CP_AW-1:0] ret_cnt_q;
  logic              rd_beat;
  logic              rd_last;
  logic              wr_beat;

  assign rd_beat = grant_rd_i & rd_pending_o;
  assign rd_last = rd_pending_o & (issue_cnt_q == len_m1_q);
  assign wr_beat = grant_wr_i & wr_pending_o;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_pending_o <= 1'b0;
      wr_pending_o <= 1'b0;
      len_m1_q     <= '0;
      issue_cnt_q  <= '0;
      ret_cnt_q    <= '0;
    end else begin
      if (rd_req_i) begin
        rd_pending_o <= 1'b1;
        len_m1_q     <= `CP_AW'(rd_len_i - 1'b1);  // A length of 8 wraps to 7.
        issue_cnt_q  <= '0;
        ret_cnt_q    <= '0;
      end else begin
        if (rd_beat) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
          if (rd_last) rd_pending_o <= 1'b0;
        end
        if (rvalid_i) ret_cnt_q <= ret_cnt_q + 1'b1;  // Returned beats lag by one cycle.
      end
      if (wr_req_i) begin
        wr_pending_o <= 1'b1;
      end else if (wr_beat) begin
        wr_pending_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req_i) begin
      addr_o <= rd_addr_i;
    end else if (wr_req_i) begin
      addr_o <= wr_addr_i;
    end else if (rd_beat) begin
      addr_o <= addr_o + 1'b1;  // Bursts wrap around the buffer.
    end
    if (wr_req_i) wdata_o <= wr_data_i;
  end

  assign last_o    = rd_last | wr_pending_o;
  assign rdata_o   = rdata_i;
  assign rvalid_o  = rvalid_i;
  assign rlast_o   = rvalid_i & (ret_cnt_q == len_m1_q);
  assign wr_done_o = wr_beat;

endmodule

/* hw/param_engine.sv */
`timescale 1ns/1ps
`include "conv_param_defs.svh"

module param_engine
  import conv_param_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     grant_i,
  input  logic [`CP_DW-1:0]        rdata_i,
  output logic                     busy_o,
  output logic                     cs_o,
  output logic [`CP_AW-1:0]        addr_o,
  output param_word_u              cfg_o,
  output logic signed [`CP_DW-1:0] weight_sum_o,
  output logic                     done_o
);

  localparam logic [`CP_AW-1:0] LastIdx = `CP_AW'(`CP_DEPTH - 1);

  logic [`CP_AW-1:0] issue_idx_q;
  logic              tag_vld_q;
  logic [`CP_AW-1:0] tag_idx_q;
  logic              start_ok;
  param_word_u       word;

  // A start while reads are still outstanding is dropped.
  assign start_ok = start_i & ~busy_o & ~tag_vld_q;
  assign cs_o     = busy_o & grant_i;
  assign addr_o   = issue_idx_q;
  assign word     = rdata_i;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      busy_o      <= 1'b0;
      issue_idx_q <= '0;
      tag_vld_q   <= 1'b0;
      tag_idx_q   <= '0;
      done_o      <= 1'b0;
    end else begin
      tag_vld_q <= cs_o;  // Tag travels alongside the SRAM read latency.
      tag_idx_q <= issue_idx_q;
      done_o    <= tag_vld_q & (tag_idx_q == LastIdx);
      if (start_ok) begin
        busy_o      <= 1'b1;
        issue_idx_q <= '0;
      end else if (cs_o) begin
        issue_idx_q <= issue_idx_q + 1'b1;
        if (issue_idx_q == LastIdx) busy_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      weight_sum_o <= '0;
    end else if (tag_vld_q) begin
      if (tag_idx_q == '0) begin
        cfg_o.cfg <= word.cfg;  // Word 0 carries the layer setup.
      end else begin
        weight_sum_o <= weight_sum_o + word.raw;
      end
    end
  end

endmodule

/* hw/conv_param_top.sv */
`timescale 1ns/1ps
`include "conv_param_defs.svh"

module conv_param_top
  import conv_param_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  input  logic                     rd_req_i,
  input  logic [`CP_AW-1:0]        rd_addr_i,
  input  logic [`CP_AW:0]          rd_len_i,
  input  logic                     wr_req_i,
  input  logic [`CP_AW-1:0]        wr_addr_i,
  input  logic [`CP_DW-1:0]        wr_data_i,
  output logic [`CP_DW-1:0]        rdata_o,
  output logic                     rvalid_o,
  output logic                     rlast_o,
  output logic                     wr_done_o,
  output logic                     done_o,
  output param_word_u              cfg_o,
  output logic signed [`CP_DW-1:0] weight_sum_o
);

  logic              rd_pending;
  logic              wr_pending;
  logic [`CP_AW-1:0] host_addr;
  logic [`CP_DW-1:0] host_wdata;
  logic              host_last;
  logic              host_grant_rd;
  logic              host_grant_wr;
  logic [`CP_DW-1:0] host_rdata;
  logic              host_rvalid;
  logic              eng_busy;
  logic              eng_cs;
  logic [`CP_AW-1:0] eng_addr;
  logic              eng_grant;
  logic [`CP_DW-1:0] eng_rdata;
  logic              sram_cs;
  logic              sram_we;
  logic [`CP_AW-1:0] sram_addr;
  logic [`CP_DW-1:0] sram_wdata;
  logic [`CP_DW-1:0] sram_rdata;

  host_bus_port u_host_port (
    .clk          (clk),
    .rst          (rst),
    .rd_req_i     (rd_req_i),
    .rd_addr_i    (rd_addr_i),
    .rd_len_i     (rd_len_i),
    .wr_req_i     (wr_req_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .grant_rd_i   (host_grant_rd),
    .grant_wr_i   (host_grant_wr),
    .rdata_i      (host_rdata),
    .rvalid_i     (host_rvalid),
    .rd_pending_o (rd_pending),
    .wr_pending_o (wr_pending),
    .addr_o       (host_addr),
    .wdata_o      (host_wdata),
    .last_o       (host_last),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .rlast_o      (rlast_o),
    .wr_done_o    (wr_done_o)
  );

  param_buffer_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .eng_busy_i      (eng_busy),
    .eng_cs_i        (eng_cs),
    .eng_addr_i      (eng_addr),
    .rd_pending_i    (rd_pending),
    .wr_pending_i    (wr_pending),
    .host_addr_i     (host_addr),
    .host_wdata_i    (host_wdata),
    .host_last_i     (host_last),
    .sram_rdata_i    (sram_rdata),
    .eng_grant_o     (eng_grant),
    .eng_rdata_o     (eng_rdata),
    .host_grant_rd_o (host_grant_rd),
    .host_grant_wr_o (host_grant_wr),
    .host_rdata_o    (host_rdata),
    .host_rvalid_o   (host_rvalid),
    .sram_cs_o       (sram_cs),
    .sram_we_o       (sram_we),
    .sram_addr_o     (sram_addr),
    .sram_wdata_o    (sram_wdata)
  );

  param_sram u_sram (
    .clk     (clk),
    .cs_i    (sram_cs),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  param_engine u_engine (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start_i),
    .grant_i      (eng_grant),
    .rdata_i      (eng_rdata),
    .busy_o       (eng_busy),
    .cs_o         (eng_cs),
    .addr_o       (eng_addr),
    .cfg_o        (cfg_o),
    .weight_sum_o (weight_sum_o),
    .done_o       (done_o)
  );

endmodule

/* sim/conv_param_assert.sv */
`timescale 1ns/1ps

module conv_param_assert
  import conv_param_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input arb_state_e state_i,
  input logic       eng_grant_i,
  input logic       host_grant_rd_i,
  input logic       host_grant_wr_i,
  input logic       sram_cs_i,
  input logic       sram_we_i,
  input logic       host_rvalid_i
);

  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    $onehot0({eng_grant_i, host_grant_rd_i, host_grant_wr_i}))
    else $error("more than one arbiter grant is high");

  a_we_in_write: assert property (@(posedge clk) disable iff (rst)
    sram_we_i |-> (state_i == ARB_HOST_WR))
    else $error("SRAM write request outside the host write state");

  // The SRAM answers one cycle after a read select.
  a_rvalid_after_cs: assert property (@(posedge clk) disable iff (rst)
    host_rvalid_i |-> $past(sram_cs_i && !sram_we_i))
    else $error("host read data valid without a preceding read select");

endmodule

bind param_buffer_arbiter conv_param_assert u_arb_assert (
  .clk             (clk),
  .rst             (rst),
  .state_i         (state_q),
  .eng_grant_i     (eng_grant_o),
  .host_grant_rd_i (host_grant_rd_o),
  .host_grant_wr_i (host_grant_wr_o),
  .sram_cs_i       (sram_cs_o),
  .sram_we_i       (sram_we_o),
  .host_rvalid_i   (host_rvalid_o)
);

/* sim/tb_conv_param.sv */
`timescale 1ns/1ps
`include "conv_param_defs.svh"

module tb_conv_param
  import conv_param_pkg::*;
();

  localparam int MaxOps       = 32;
  localparam int OpWr         = 0;
  localparam int OpRd         = 1;
  localparam int OpEng        = 2;
  localparam int OpEngRd      = 3;
  localparam int EngineCycles = 11;

  logic                     clk;
  logic                     rst;
  logic                     start_i;
  logic                     rd_req_i;
  logic [`CP_AW-1:0]        rd_addr_i;
  logic [`CP_AW:0]          rd_len_i;
  logic                     wr_req_i;
  logic [`CP_AW-1:0]        wr_addr_i;
  logic [`CP_DW-1:0]        wr_data_i;
  logic [`CP_DW-1:0]        rdata_o;
  logic                     rvalid_o;
  logic                     rlast_o;
  logic                     wr_done_o;
  logic                     done_o;
  param_word_u              cfg_o;
  logic signed [`CP_DW-1:0] weight_sum_o;

  int                op_kind [MaxOps];
  logic [`CP_AW-1:0] op_addr [MaxOps];
  logic [`CP_AW:0]   op_len  [MaxOps];
  logic [`CP_DW-1:0] op_data [MaxOps];
  logic [`CP_DW-1:0] model   [`CP_DEPTH];
  logic [31:0]       lcg_state;
  int                n_ops;
  int                err_cnt;
  int                chk_cnt;
  int                cycle_cnt;
  int                cycle_limit;

  conv_param_top DUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: no result after %0d cycles", cycle_cnt);
      $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt + 1);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic signed [`CP_DW-1:0] weight_total();
    logic signed [`CP_DW-1:0] acc;
    acc = '0;
    for (int i = 1; i < `CP_DEPTH; i++) acc = acc + $signed(model[i]);  // Wraps modulo 2^32.
    return acc;
  endfunction

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic check_data(input string name, input logic [`CP_DW-1:0] got,
                            input logic [`CP_DW-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cfg(input param_word_u got, input param_word_u exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: cfg_o got %h expected %h", got, exp);
    end
  endtask

  task automatic check_sum(input logic signed [`CP_DW-1:0] got,
                           input logic signed [`CP_DW-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: weight_sum_o got %h expected %h", got, exp);
    end
  endtask

  task automatic check_outputs_idle(input string when);
    if ({rvalid_o, rlast_o, wr_done_o, done_o} !== 4'b0000) begin
      note_failure($sformatf("a response flag was high %s", when));
    end
  endtask

  task automatic add_op(input int kind, input logic [`CP_AW-1:0] addr,
                        input logic [`CP_AW:0] len, input logic [`CP_DW-1:0] data);
    op_kind[n_ops] = kind;
    op_addr[n_ops] = addr;
    op_len[n_ops]  = len;
    op_data[n_ops] = data;
    n_ops++;
  endtask

  task automatic build_table();
    lcg_state = 32'h040a_ae99;
    n_ops = 0;
    add_op(OpWr, 3'd0, 4'd1, 32'h1020_3110);  // 16 out, 32 in, 3x3 kernel, stride 1, pad 1.
    for (int i = 1; i < `CP_DEPTH; i++) begin
      lcg_state = lcg_next(lcg_state);
      add_op(OpWr, `CP_AW'(i), 4'd1, lcg_state);
    end
    for (int i = 0; i < `CP_DEPTH; i++) add_op(OpRd, `CP_AW'(i), 4'd1, '0);
    add_op(OpRd, 3'd5, 4'd6, '0);
    add_op(OpRd, 3'd0, 4'd8, '0);
    add_op(OpRd, 3'd3, 4'd3, '0);
    add_op(OpEng, 3'd0, 4'd0, '0);
    lcg_state = lcg_next(lcg_state);
    add_op(OpWr, 3'd3, 4'd1, lcg_state);
    add_op(OpWr, 3'd0, 4'd1, 32'h4008_5220);
    add_op(OpEngRd, 3'd6, 4'd2, '0);  // Engine and host read requested together.
    add_op(OpEng, 3'd0, 4'd0, '0);
    add_op(OpRd, 3'd0, 4'd1, '0);
  endtask

  task automatic run_op(input int idx);
    int                       kind;
    int                       rd_left;
    int                       wr_left;
    int                       beat;
    int                       cycles;
    bit                       eng_wait;
    logic [`CP_AW-1:0]        exp_addr;
    param_word_u              exp_cfg;
    logic signed [`CP_DW-1:0] exp_sum;
    kind     = op_kind[idx];
    exp_addr = op_addr[idx];
    rd_left  = (kind == OpRd || kind == OpEngRd) ? int'(op_len[idx]) : 0;
    wr_left  = (kind == OpWr) ? 1 : 0;
    eng_wait = (kind == OpEng || kind == OpEngRd);
    beat     = 0;
    cycles   = 0;
    @(posedge clk);
    if (kind == OpWr) begin
      wr_req_i  <= 1'b1;
      wr_addr_i <= op_addr[idx];
      wr_data_i <= op_data[idx];
      model[op_addr[idx]] = op_data[idx];
    end
    if (rd_left > 0) begin
      rd_req_i  <= 1'b1;
      rd_addr_i <= op_addr[idx];
      rd_len_i  <= op_len[idx];
    end
    if (eng_wait) start_i <= 1'b1;
    @(posedge clk);
    wr_req_i <= 1'b0;
    rd_req_i <= 1'b0;
    start_i  <= 1'b0;
    exp_cfg.cfg.out_ch   = model[0][31:24];
    exp_cfg.cfg.in_ch    = model[0][23:16];
    exp_cfg.cfg.kernel   = model[0][15:12];
    exp_cfg.cfg.stride   = model[0][11:8];
    exp_cfg.cfg.pad      = model[0][7:4];
    exp_cfg.cfg.reserved = model[0][3:0];
    exp_sum = weight_total();
    while (eng_wait || beat < rd_left || wr_left > 0) begin
      @(negedge clk);
      cycles++;
      if (done_o === 1'b1) begin
        if (!eng_wait) begin
          note_failure("done_o pulsed with no engine run active");
        end else begin
          eng_wait = 1'b0;
          if (kind == OpEng && cycles != EngineCycles) begin
            note_failure($sformatf("engine took %0d cycles instead of %0d", cycles,
                                   EngineCycles));
          end
          if (beat != 0) note_failure("host read data came back before the engine finished");
          check_cfg(cfg_o, exp_cfg);
          check_sum(weight_sum_o, exp_sum);
        end
      end
      if (rvalid_o === 1'b1) begin
        if (beat >= rd_left) begin
          note_failure("rvalid_o beat beyond the burst length");
        end else begin
          check_data("rdata_o", rdata_o, model[exp_addr]);
          if (rlast_o !== (beat == rd_left - 1)) begin
            note_failure($sformatf("rlast_o wrong on beat %0d of %0d", beat + 1, rd_left));
          end
          exp_addr = exp_addr + 3'd1;  // Bursts wrap modulo the depth.
          beat++;
        end
      end else if (rlast_o === 1'b1) begin
        note_failure("rlast_o set without rvalid_o");
      end
      if (wr_done_o === 1'b1) begin
        if (wr_left == 0) note_failure("wr_done_o pulsed with no write active");
        wr_left = 0;
      end
    end
    repeat (3) begin
      @(negedge clk);
      check_outputs_idle($sformatf("after operation %0d ended", idx));
    end
  endtask

  initial begin
    err_cnt     = 0;
    chk_cnt     = 0;
    cycle_cnt   = 0;
    rst       <= 1'b1;
    start_i   <= 1'b0;
    rd_req_i  <= 1'b0;
    rd_addr_i <= '0;
    rd_len_i  <= '0;
    wr_req_i  <= 1'b0;
    wr_addr_i <= '0;
    wr_data_i <= '0;
    for (int i = 0; i < `CP_DEPTH; i++) model[i] = '0;
    build_table();
    cycle_limit = 40 * n_ops + 100;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_outputs_idle("after reset before any request");
    end
    for (int i = 0; i < n_ops; i++) run_op(i);
    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/conv_param_pkg.sv
hw/param_sram.sv
hw/param_buffer_arbiter.sv
hw/host_bus_port.sv
hw/param_engine.sv
hw/conv_param_top.sv
sim/conv_param_assert.sv
sim/tb_conv_param.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_conv_param -f tb.f -o tb_conv_param; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_conv_param)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
